/* include/cpu_defs_defs.svh */
`ifndef CPU_DEFS_DEFS_SVH
`define CPU_DEFS_DEFS_SVH

`define CPU_DATA_W 8     // byte datapath
`define CPU_ADDR_W 16    // flat 64k address space
`define CPU_NREGS  8
`define CPU_QDEPTH 4     // prefetch bytes

// flag word layout
`define CPU_FS 3
`define CPU_FZ 2
`define CPU_FV 1
`define CPU_FC 0

`endif

/* source/cpu_pkg.sv */
package cpu_pkg;

    typedef enum logic [2:0] {
        ALU_PASS,    // b straight through, flags untouched
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_e;

    // class of the first instruction byte
    typedef enum logic [2:0] {
        OP_NOP,
        OP_HALT,
        OP_LDI,      // LD r,#n
        OP_LDM,      // LD r,(addr16)
        OP_STM,      // LD (addr16),r
        OP_JPC,      // JP cc,addr16
        OP_PREFIX,   // register prefix, ALU op in second byte
        OP_OTHER
    } opcode_e;

    typedef enum logic [3:0] {
        CC_F, CC_LT, CC_LE, CC_ULE, CC_OV, CC_MI, CC_EQ, CC_C,
        CC_T, CC_GE, CC_GT, CC_UGT, CC_NOV, CC_PL, CC_NE, CC_NC
    } cond_e;

    typedef enum logic [2:0] {
        SEQ_DECODE,
        SEQ_EXEC2,   // register/flag write cycle
        SEQ_LD_MEM,
        SEQ_ST_MEM,
        SEQ_HALTED
    } seq_state_e;

endpackage

/* source/mem_req_if.sv */
`timescale 1ns/1ps
`include "cpu_defs_defs.svh"

interface mem_req_if;
    logic                   req;
    logic                   we;
    logic [`CPU_ADDR_W-1:0] addr;
    logic [`CPU_DATA_W-1:0] wdata;
    logic [`CPU_DATA_W-1:0] rdata;
    logic                   done;    // single-cycle pulse, rdata valid with it

    modport requester (
        output req, we, addr, wdata,
        input  rdata, done
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, done
    );
endinterface

/* source/alu_unit.sv */
`timescale 1ns/1ps
`include "cpu_defs_defs.svh"

module alu_unit
    import cpu_pkg::*;
(
    input  alu_op_e                op,
    input  logic [`CPU_DATA_W-1:0] a,
    input  logic [`CPU_DATA_W-1:0] b,
    input  logic [3:0]             flags_in,
    output logic [`CPU_DATA_W-1:0] result,
    output logic [3:0]             flags_out
);
    localparam int MSB = `CPU_DATA_W - 1;

    logic [`CPU_DATA_W:0] sum;   // extra bit is carry/borrow
    logic                 ovf;

    always_comb begin
        ovf = 1'b0;
        case (op)
            ALU_ADD: begin
                sum = {1'b0, a} + {1'b0, b};
                ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
            end
            ALU_SUB: begin
                sum = {1'b0, a} - {1'b0, b};
                ovf = (a[MSB] != b[MSB]) && (sum[MSB] != a[MSB]);
            end
            ALU_AND: sum = {1'b0, a & b};
            ALU_OR:  sum = {1'b0, a | b};
            default: sum = {1'b0, b};   // pass
        endcase
        result    = sum[MSB:0];
        flags_out = flags_in;
        if (op != ALU_PASS) begin
            flags_out[`CPU_FS] = result[MSB];
            flags_out[`CPU_FZ] = (result == '0);
            flags_out[`CPU_FV] = ovf;
            flags_out[`CPU_FC] = sum[`CPU_DATA_W];
        end
    end
endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps
`include "cpu_defs_defs.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [2:0]             rd_a,
    input  logic [2:0]             rd_b,
    input  logic [2:0]             wr_sel,
    input  logic [`CPU_DATA_W-1:0] wr_data,
    input  logic                   reg_we,
    input  logic                   flag_we,
    input  logic [3:0]             flags_new,
    output logic [`CPU_DATA_W-1:0] rd_a_data,
    output logic [`CPU_DATA_W-1:0] rd_b_data,
    output logic [3:0]             flags
);
    logic [`CPU_DATA_W-1:0] regs [`CPU_NREGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NREGS; i++)
                regs[i] <= '0;
            flags <= '0;
        end else begin
            if (reg_we)
                regs[wr_sel] <= wr_data;
            if (flag_we)
                flags <= flags_new;
        end
    end

    assign rd_a_data = regs[rd_a];   // asynchronous read
    assign rd_b_data = regs[rd_b];
endmodule

/* source/fetch_queue.sv */
`timescale 1ns/1ps
`include "cpu_defs_defs.svh"

module fetch_queue (
    input  logic                        clk,
    input  logic                        rst,
    mem_req_if.requester                mem,
    output logic [2:0][`CPU_DATA_W-1:0] q_bytes,
    output logic [2:0]                  q_count,
    input  logic [1:0]                  consume,
    input  logic                        flush,
    input  logic [`CPU_ADDR_W-1:0]      flush_addr
);
    logic [`CPU_DATA_W-1:0] q [`CPU_QDEPTH];
    logic [`CPU_ADDR_W-1:0] fetch_addr;   // next byte to request
    logic [`CPU_ADDR_W-1:0] next_addr;
    logic [`CPU_ADDR_W-1:0] req_addr;     // held on the bus until done
    logic                   req_q;
    logic                   discard;      // in-flight byte is from a flushed stream
    logic                   wr_byte;
    logic                   start;
    logic [2:0]             count_cons;
    logic [2:0]             count_next;

    assign wr_byte    = mem.done && !discard && !flush;
    assign count_cons = q_count - {1'b0, consume};
    assign count_next = flush ? 3'd0 : count_cons + {2'b00, wr_byte};
    assign next_addr  = flush ? flush_addr : fetch_addr;
    // one transfer outstanding at most, so count_next already holds its byte
    assign start      = (!req_q || mem.done) && (count_next < 3'(`CPU_QDEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q_count    <= '0;
            fetch_addr <= '0;
            req_addr   <= '0;
            req_q      <= 1'b0;
            discard    <= 1'b0;
        end else begin
            q_count <= count_next;
            if (start) begin
                req_q      <= 1'b1;
                req_addr   <= next_addr;
                fetch_addr <= next_addr + 1'b1;
            end else begin
                if (mem.done)
                    req_q <= 1'b0;
                if (flush)
                    fetch_addr <= flush_addr;
            end
            if (mem.done)
                discard <= 1'b0;
            else if (flush && req_q)
                discard <= 1'b1;   // let the old transfer finish on the bus
        end
    end

    // shift out consumed bytes, append at the new tail
    always_ff @(posedge clk) begin
        for (int i = 0; i < `CPU_QDEPTH; i++) begin
            if (i + consume < `CPU_QDEPTH)
                q[i] <= q[i + consume];
        end
        if (wr_byte)
            q[count_cons[1:0]] <= mem.rdata;
    end

    assign q_bytes   = {q[2], q[1], q[0]};
    assign mem.req   = req_q;
    assign mem.we    = 1'b0;   // read only
    assign mem.addr  = req_addr;
    assign mem.wdata = '0;
endmodule

/* source/load_store.sv */
`timescale 1ns/1ps
`include "cpu_defs_defs.svh"

module load_store (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   we,
    input  logic [`CPU_ADDR_W-1:0] addr,
    input  logic [`CPU_DATA_W-1:0] wdata,
    output logic                   done,
    output logic [`CPU_DATA_W-1:0] rdata,
    mem_req_if.requester           mem
);
    logic                   req_q;
    logic                   we_q;
    logic [`CPU_ADDR_W-1:0] addr_q;
    logic [`CPU_DATA_W-1:0] wdata_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= mem.done;   // rdata valid alongside
            if (start)
                req_q <= 1'b1;
            else if (mem.done)
                req_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            we_q    <= we;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (mem.done && !we_q)
            rdata <= mem.rdata;
    end

    assign mem.req   = req_q;
    assign mem.we    = we_q;
    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;
endmodule

/* source/decode_ctrl.sv */
`timescale 1ns/1ps
`include "cpu_defs_defs.svh"

module decode_ctrl
    import cpu_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [2:0][`CPU_DATA_W-1:0] q_bytes,
    input  logic [2:0]                  q_count,
    output logic [1:0]                  consume,
    output logic                        flush,
    output logic [`CPU_ADDR_W-1:0]      flush_addr,
    output logic [2:0]                  rd_a,
    output logic [2:0]                  rd_b,
    output logic [2:0]                  wr_sel,
    input  logic [`CPU_DATA_W-1:0]      rd_a_data,
    input  logic [`CPU_DATA_W-1:0]      rd_b_data,
    output alu_op_e                     alu_op,
    output logic                        alu_src_imm,
    output logic [`CPU_DATA_W-1:0]      imm,
    output logic                        reg_we,
    output logic                        flag_we,
    input  logic [3:0]                  flags,
    output logic                        ls_start,
    output logic                        ls_we,
    output logic [`CPU_ADDR_W-1:0]      ls_addr,
    input  logic                        ls_done,
    input  logic [`CPU_DATA_W-1:0]      ls_rdata,
    output logic                        halted
);
    seq_state_e             state;
    opcode_e                opc;
    alu_op_e                pfx_op;
    logic [1:0]             len;       // instruction length in bytes
    logic                   ready;
    logic                   taken;
    logic                   pfx_ok;
    logic                   reg_we_q;
    logic [`CPU_DATA_W-1:0] imm_q;

    function automatic logic cond_true(input cond_e cc, input logic [3:0] f);
        logic lt;
        logic base;
        lt = f[`CPU_FS] ^ f[`CPU_FV];
        case (cond_e'({1'b0, cc[2:0]}))
            CC_F:    base = 1'b0;
            CC_LT:   base = lt;
            CC_LE:   base = f[`CPU_FZ] | lt;
            CC_ULE:  base = f[`CPU_FZ] | f[`CPU_FC];
            CC_OV:   base = f[`CPU_FV];
            CC_MI:   base = f[`CPU_FS];
            CC_EQ:   base = f[`CPU_FZ];
            default: base = f[`CPU_FC];
        endcase
        return base ^ cc[3];   // upper eight invert the lower eight
    endfunction

    always_comb begin
        casez (q_bytes[0])
            8'h00:        opc = OP_NOP;
            8'h05:        opc = OP_HALT;
            8'b0010_0???: opc = OP_LDI;
            8'b0011_0???: opc = OP_LDM;
            8'b0100_0???: opc = OP_STM;
            8'b1101_????: opc = OP_JPC;
            8'b1100_1???: opc = OP_PREFIX;
            default:      opc = OP_OTHER;
        endcase
        case (opc)
            OP_LDI, OP_PREFIX:      len = 2'd2;
            OP_LDM, OP_STM, OP_JPC: len = 2'd3;
            default:                len = 2'd1;
        endcase
        case (q_bytes[1][6:5])
            2'd0:    pfx_op = ALU_ADD;
            2'd1:    pfx_op = ALU_SUB;
            2'd2:    pfx_op = ALU_AND;
            default: pfx_op = ALU_OR;
        endcase
    end

    assign pfx_ok     = q_bytes[1][7] && (q_bytes[1][4:3] == 2'b00);   // 80h/A0h/C0h/E0h + r
    assign taken      = cond_true(cond_e'(q_bytes[0][3:0]), flags);
    assign ready      = (state == SEQ_DECODE) && (q_count >= {1'b0, len});
    assign consume    = ready ? len : 2'd0;
    assign flush      = ready && (opc == OP_JPC) && taken;
    assign flush_addr = {q_bytes[2], q_bytes[1]};
    assign reg_we     = reg_we_q | ((state == SEQ_LD_MEM) && ls_done);

    // b operand: register, immediate, load data, or store data for load_store
    always_comb begin
        if (!alu_src_imm)
            imm = rd_b_data;
        else if (state == SEQ_LD_MEM)
            imm = ls_rdata;
        else if (state == SEQ_ST_MEM)
            imm = rd_a_data;
        else
            imm = imm_q;
    end

    always_ff @(posedge clk) begin
        if (ready) begin
            rd_a    <= q_bytes[0][2:0];   // R, or r of a store
            rd_b    <= q_bytes[1][2:0];
            wr_sel  <= q_bytes[0][2:0];
            imm_q   <= q_bytes[1];
            ls_addr <= {q_bytes[2], q_bytes[1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= SEQ_DECODE;
            alu_op      <= ALU_PASS;
            alu_src_imm <= 1'b1;
            reg_we_q    <= 1'b0;
            flag_we     <= 1'b0;
            ls_start    <= 1'b0;
            ls_we       <= 1'b0;
            halted      <= 1'b0;
        end else begin
            reg_we_q <= 1'b0;
            flag_we  <= 1'b0;
            ls_start <= 1'b0;
            case (state)
                SEQ_DECODE: if (ready) begin
                    alu_op      <= (opc == OP_PREFIX) ? pfx_op : ALU_PASS;
                    alu_src_imm <= (opc != OP_PREFIX);
                    ls_we       <= (opc == OP_STM);
                    case (opc)
                        OP_HALT: state <= SEQ_HALTED;
                        OP_LDI: begin
                            reg_we_q <= 1'b1;
                            state    <= SEQ_EXEC2;
                        end
                        OP_PREFIX: if (pfx_ok) begin
                            reg_we_q <= 1'b1;
                            flag_we  <= 1'b1;
                            state    <= SEQ_EXEC2;
                        end
                        OP_LDM: begin
                            ls_start <= 1'b1;
                            state    <= SEQ_LD_MEM;
                        end
                        OP_STM: begin
                            ls_start <= 1'b1;
                            state    <= SEQ_ST_MEM;
                        end
                        default: ;   // NOP, untaken jump, unknown byte
                    endcase
                end
                SEQ_EXEC2: state <= SEQ_DECODE;
                SEQ_LD_MEM, SEQ_ST_MEM: if (ls_done) state <= SEQ_DECODE;
                default: begin
                    // full queue means no fetch left on the bus
                    if (q_count == 3'(`CPU_QDEPTH))
                        halted <= 1'b1;
                end
            endcase
        end
    end
endmodule

/* source/bus_arbiter.sv */
`timescale 1ns/1ps
`include "cpu_defs_defs.svh"

module bus_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    mem_req_if.arbiter             fetch,
    mem_req_if.arbiter             data,
    output logic                   psel,
    output logic                   penable,
    output logic                   pwrite,
    output logic [`CPU_ADDR_W-1:0] paddr,
    output logic [`CPU_DATA_W-1:0] pwdata,
    input  logic [`CPU_DATA_W-1:0] prdata,
    input  logic                   pready
);
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_SETUP,
        PH_ACCESS
    } phase_e;

    phase_e phase;
    logic   own_data;   // owner of the running transfer
    logic   xfer_end;

    assign xfer_end = (phase == PH_ACCESS) && pready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= PH_IDLE;
            own_data <= 1'b0;
        end else begin
            case (phase)
                PH_IDLE: if (data.req || fetch.req) begin
                    own_data <= data.req;   // data wins over fetch
                    phase    <= PH_SETUP;
                end
                PH_SETUP: phase <= PH_ACCESS;
                default: if (pready) phase <= PH_IDLE;   // wait states hold here
            endcase
        end
    end

    assign psel    = (phase != PH_IDLE);
    assign penable = (phase == PH_ACCESS);
    assign pwrite  = psel && (own_data ? data.we : fetch.we);
    assign paddr   = own_data ? data.addr : fetch.addr;
    assign pwdata  = own_data ? data.wdata : fetch.wdata;

    assign data.done   = xfer_end && own_data;
    assign fetch.done  = xfer_end && !own_data;
    assign data.rdata  = prdata;
    assign fetch.rdata = prdata;
endmodule

/* source/cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_defs_defs.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    output logic                   psel,
    output logic                   penable,
    output logic                   pwrite,
    output logic [`CPU_ADDR_W-1:0] paddr,
    output logic [`CPU_DATA_W-1:0] pwdata,
    input  logic [`CPU_DATA_W-1:0] prdata,
    input  logic                   pready,
    output logic                   halted
);
    logic [2:0][`CPU_DATA_W-1:0] q_bytes;
    logic [2:0]                  q_count;
    logic [1:0]                  consume;
    logic                        flush;
    logic [`CPU_ADDR_W-1:0]      flush_addr;
    logic [2:0]                  rd_a;
    logic [2:0]                  rd_b;
    logic [2:0]                  wr_sel;
    logic [`CPU_DATA_W-1:0]      rd_a_data;
    logic [`CPU_DATA_W-1:0]      rd_b_data;
    alu_op_e                     alu_op;
    logic [`CPU_DATA_W-1:0]      operand_b;   // from decode mux
    logic [`CPU_DATA_W-1:0]      alu_result;
    logic                        reg_we;
    logic                        flag_we;
    logic [3:0]                  flags;
    logic [3:0]                  flags_new;
    logic                        ls_start;
    logic                        ls_we;
    logic [`CPU_ADDR_W-1:0]      ls_addr;
    logic                        ls_done;
    logic [`CPU_DATA_W-1:0]      ls_rdata;

    mem_req_if fetch_if ();
    mem_req_if data_if ();

    fetch_queue i_fetch_queue (
        .clk        (clk),
        .rst        (rst),
        .mem        (fetch_if.requester),
        .q_bytes    (q_bytes),
        .q_count    (q_count),
        .consume    (consume),
        .flush      (flush),
        .flush_addr (flush_addr)
    );

    decode_ctrl i_decode_ctrl (
        .clk         (clk),
        .rst         (rst),
        .q_bytes     (q_bytes),
        .q_count     (q_count),
        .consume     (consume),
        .flush       (flush),
        .flush_addr  (flush_addr),
        .rd_a        (rd_a),
        .rd_b        (rd_b),
        .wr_sel      (wr_sel),
        .rd_a_data   (rd_a_data),
        .rd_b_data   (rd_b_data),
        .alu_op      (alu_op),
        .alu_src_imm (),
        .imm         (operand_b),
        .reg_we      (reg_we),
        .flag_we     (flag_we),
        .flags       (flags),
        .ls_start    (ls_start),
        .ls_we       (ls_we),
        .ls_addr     (ls_addr),
        .ls_done     (ls_done),
        .ls_rdata    (ls_rdata),
        .halted      (halted)
    );

    reg_file i_reg_file (
        .clk       (clk),
        .rst       (rst),
        .rd_a      (rd_a),
        .rd_b      (rd_b),
        .wr_sel    (wr_sel),
        .wr_data   (alu_result),
        .reg_we    (reg_we),
        .flag_we   (flag_we),
        .flags_new (flags_new),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data),
        .flags     (flags)
    );

    alu_unit i_alu_unit (
        .op        (alu_op),
        .a         (rd_a_data),
        .b         (operand_b),
        .flags_in  (flags),
        .result    (alu_result),
        .flags_out (flags_new)
    );

    // store data arrives through the decode operand mux
    load_store i_load_store (
        .clk   (clk),
        .rst   (rst),
        .start (ls_start),
        .we    (ls_we),
        .addr  (ls_addr),
        .wdata (operand_b),
        .done  (ls_done),
        .rdata (ls_rdata),
        .mem   (data_if.requester)
    );

    bus_arbiter i_bus_arbiter (
        .clk     (clk),
        .rst     (rst),
        .fetch   (fetch_if.arbiter),
        .data    (data_if.arbiter),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );
endmodule

/* sim/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
    localparam int CLK_PERIOD      = 4;
    localparam int NUM_PROGS       = 4;
    localparam int CYCLES_PER_PROG = 4000;

    logic        clk    = 1'b0;
    logic        rst    = 1'b0;
    logic        pready = 1'b0;
    logic [7:0]  prdata = 8'h00;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    logic [7:0]  pwdata;
    logic        halted;

    logic [31:0] seed = 32'h3832;
    logic [7:0]  mem [1024];   // APB memory seen by the DUT
    logic [7:0]  mm [1024];    // model copy
    logic [15:0] wp;           // program write pointer
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    int          errors   = 0;
    int          n_writes = 0;
    int          waits    = 0;
    bit          first_rd = 1'b0;

    cpu_top i_cpu_top (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .halted  (halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned rnd(input int unsigned range);
        seed = seed * 32'd1103515245 + 32'd12345;
        return (seed >> 16) % range;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // jump conditions over the {S,Z,V,C} flag word
    function automatic bit cond_hold(input logic [3:0] cc, input logic [3:0] f);
        bit s;
        bit z;
        bit v;
        bit c;
        {s, z, v, c} = f;
        case (cc)
            4'd0:    return 1'b0;          // F
            4'd1:    return s ^ v;         // LT
            4'd2:    return z | (s ^ v);   // LE
            4'd3:    return z | c;         // ULE
            4'd4:    return v;             // OV
            4'd5:    return s;             // MI
            4'd6:    return z;             // EQ
            4'd7:    return c;             // C
            4'd8:    return 1'b1;          // T
            4'd9:    return !(s ^ v);
            4'd10:   return !(z | (s ^ v));
            4'd11:   return !(z | c);
            4'd12:   return !v;
            4'd13:   return !s;
            4'd14:   return !z;
            default: return !c;            // NC
        endcase
    endfunction

    task automatic emit(input logic [7:0] b);
        mem[wp[9:0]] = b;
        wp = wp + 16'd1;
    endtask

    task automatic gen_program();
        logic [15:0] ea;
        logic [15:0] tgt;
        logic [3:0]  inv_cc [4];
        int          kind;
        int          skip;
        inv_cc = '{4'd13, 4'd14, 4'd12, 4'd15};   // PL, NE, NOV, NC
        for (int i = 0; i < 1024; i++)
            mem[10'(i)] = 8'(rnd(256));   // data region at 200h keeps these
        wp = '0;
        while (wp < 16'd300) begin
            kind = int'(rnd(10));
            if (kind < 3) begin
                emit(8'h20 | 8'(rnd(8)));
                emit(8'(rnd(256)));
            end else if (kind < 6) begin
                emit(8'hC8 | 8'(rnd(8)));
                emit(8'h80 + 8'(rnd(4) * 32) + 8'(rnd(8)));   // ADD/SUB/AND/OR
            end else if (kind < 7) begin
                ea = 16'h0200 + 16'(rnd(256));
                emit(8'h30 | 8'(rnd(8)));
                emit(ea[7:0]);
                emit(ea[15:8]);
            end else if (kind < 8) begin
                ea = 16'h0380 + 16'(rnd(64));
                emit(8'h40 | 8'(rnd(8)));
                emit(ea[7:0]);
                emit(ea[15:8]);
            end else if (kind < 9) begin
                skip = int'(rnd(3));
                tgt = wp + 16'd3 + 16'(2 * skip);   // forward over the skipped loads
                emit(8'hD0 | 8'(rnd(16)));
                emit(tgt[7:0]);
                emit(tgt[15:8]);
                for (int k = 0; k < skip; k++) begin
                    emit(8'h20 | 8'(rnd(8)));
                    emit(8'(rnd(256)));
                end
            end else begin
                emit(rnd(2) == 0 ? 8'h00 : 8'hFF);
            end
        end
        for (int i = 0; i < 8; i++) begin
            emit(8'h40 | 8'(i));   // register dump to 300h+r
            emit(8'(i));
            emit(8'h03);
        end
        for (int i = 0; i < 4; i++) begin
            tgt = wp + 16'd6;
            emit(8'hD0 | {4'h0, inv_cc[i]});
            emit(tgt[7:0]);
            emit(tgt[15:8]);
            emit(8'h40);   // marker at 310h+i only reached with the flag set
            emit(8'h10 + 8'(i));
            emit(8'h03);
        end
        emit(8'h05);
    endtask

    task automatic run_model();
        logic [7:0]  r [8];
        logic [3:0]  f;
        logic [15:0] pc;
        logic [15:0] ea;
        logic [7:0]  op;
        logic [7:0]  b1;
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  res;
        int          ures;
        int          sres;
        bit          valid;
        bit          stop;
        for (int i = 0; i < 1024; i++)
            mm[10'(i)] = mem[10'(i)];
        for (int i = 0; i < 8; i++)
            r[i] = '0;
        f = '0;
        pc = '0;
        stop = 1'b0;
        exp_addr.delete();
        exp_data.delete();
        while (!stop) begin
            op = mm[pc[9:0]];
            b1 = mm[10'(pc + 16'd1)];
            ea = {mm[10'(pc + 16'd2)], b1};
            case (op) inside
                8'h05: stop = 1'b1;
                [8'h20:8'h27]: begin
                    r[op[2:0]] = b1;
                    pc = pc + 16'd2;
                end
                [8'h30:8'h37]: begin
                    r[op[2:0]] = mm[ea[9:0]];
                    pc = pc + 16'd3;
                end
                [8'h40:8'h47]: begin
                    mm[ea[9:0]] = r[op[2:0]];
                    exp_addr.push_back(ea);
                    exp_data.push_back(r[op[2:0]]);
                    pc = pc + 16'd3;
                end
                [8'hD0:8'hDF]: pc = cond_hold(op[3:0], f) ? ea : pc + 16'd3;
                [8'hC8:8'hCF]: begin
                    a = r[op[2:0]];
                    b = r[b1[2:0]];
                    valid = 1'b1;
                    sres = 0;
                    case (b1[7:3])
                        5'h10: begin
                            ures = int'(a) + int'(b);
                            sres = int'($signed(a)) + int'($signed(b));
                        end
                        5'h14: begin
                            ures = int'(a) - int'(b);   // negative means a borrow
                            sres = int'($signed(a)) - int'($signed(b));
                        end
                        5'h18: ures = int'(a & b);
                        5'h1C: ures = int'(a | b);
                        default: begin
                            ures = 0;
                            valid = 1'b0;
                        end
                    endcase
                    if (valid) begin
                        res = 8'(ures);
                        r[op[2:0]] = res;
                        f = {res[7], res == 8'd0, (sres > 127) || (sres < -128),
                             (ures > 255) || (ures < 0)};
                    end
                    pc = pc + 16'd2;
                end
                default: pc = pc + 16'd1;
            endcase
        end
    endtask

    // APB slave with 0 to 3 wait states and the write trace check
    always @(posedge clk) begin
        if (rst) begin
            pready <= 1'b0;
            prdata <= 8'h00;
            first_rd = 1'b1;
            check_eq(32'(psel), 32'd0, "psel in reset");
            check_eq(32'(penable), 32'd0, "penable in reset");
            check_eq(32'(halted), 32'd0, "halted in reset");
        end else if (psel && !penable) begin
            if (first_rd && !pwrite) begin
                check_eq(32'(paddr), 32'd0, "first fetch address");
                first_rd = 1'b0;
            end
            waits = int'(rnd(4));
            if (waits == 0) begin
                pready <= 1'b1;
                prdata <= mem[paddr[9:0]];
            end
        end else if (psel && penable && !pready) begin
            if (waits <= 1) begin
                pready <= 1'b1;
                prdata <= mem[paddr[9:0]];
            end
            waits = waits - 1;
        end else if (psel && penable && pready) begin
            pready <= 1'b0;
            if (pwrite) begin
                mem[paddr[9:0]] = pwdata;
                if (exp_addr.size() == 0) begin
                    $display("Unexpected APB write of %h to %h outside the store trace",
                             pwdata, paddr);
                    errors++;
                end else begin
                    check_eq(32'(paddr), 32'(exp_addr.pop_front()), "store address");
                    check_eq(32'(pwdata), 32'(exp_data.pop_front()), "store data");
                    n_writes++;
                end
            end
        end
    end

    initial begin
        int base;
        for (int p = 0; p < NUM_PROGS; p++) begin
            rst <= 1'b1;
            gen_program();
            run_model();
            base = n_writes;
            repeat (16) @(posedge clk);
            rst <= 1'b0;
            while (!halted)
                @(posedge clk);
            repeat (50) begin
                @(posedge clk);
                check_eq(32'(psel), 32'd0, "psel after halt");
            end
            if (exp_addr.size() != 0) begin
                $display("Program %0d halted with %0d expected stores never written",
                         p, exp_addr.size());
                errors++;
            end
            $display("program %0d finished: %0d stores checked, %0d errors so far",
                     p, n_writes - base, errors);
        end
        $display("%0d programs, %0d stores checked, %0d errors", NUM_PROGS, n_writes, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        #(CYCLES_PER_PROG * NUM_PROGS * CLK_PERIOD);
        $display("Timeout: the CPU did not reach HALT within the allowed run time");
        $display("SIMULATION FAILED");
        $finish;
    end
endmodule

/* filelist.f */
+incdir+include
source/cpu_pkg.sv
source/mem_req_if.sv
source/alu_unit.sv
source/reg_file.sv
source/fetch_queue.sv
source/load_store.sv
source/decode_ctrl.sv
source/bus_arbiter.sv
source/cpu_top.sv
sim/tb_cpu.sv

/* Makefile */
TOP = tb_cpu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
